// ==== rtl/cpuId_macros.svh ====
`ifndef CPUID_MACROS_SVH
`define CPUID_MACROS_SVH

// identity string "BJX2F2  ", first character in the low byte
`define CPUID_IDENT 64'h2020324632584A42

// feature flag bits, bit 0 lands on bit 8 of the feature word
`define CPUID_FLAG_WEX       (22'h1 << 0)
`define CPUID_FLAG_WEX3W     (22'h1 << 1)
`define CPUID_FLAG_JUMBO     (22'h1 << 2)
`define CPUID_FLAG_MMU       (22'h1 << 3)
`define CPUID_FLAG_VADDR48   (22'h1 << 4)
`define CPUID_FLAG_FPU       (22'h1 << 7)
`define CPUID_FLAG_FPU_W     (22'h1 << 8)
`define CPUID_FLAG_FMAC      (22'h1 << 10)
`define CPUID_FLAG_PRED      (22'h1 << 13)
`define CPUID_FLAG_CMPTAG    (22'h1 << 17)
`define CPUID_FLAG_RIDISP    (22'h1 << 21)

// flags this build reports
`define CPUID_FEATURE_FLAGS ( \
	`CPUID_FLAG_WEX | `CPUID_FLAG_WEX3W | `CPUID_FLAG_JUMBO | \
	`CPUID_FLAG_MMU | `CPUID_FLAG_VADDR48 | `CPUID_FLAG_FPU | \
	`CPUID_FLAG_FPU_W | `CPUID_FLAG_FMAC | `CPUID_FLAG_PRED | \
	`CPUID_FLAG_CMPTAG | `CPUID_FLAG_RIDISP)

// request credits, also the result queue depth
`define CPUID_REQ_CREDITS 4

// response credits granted by the consumer at reset
`define CPUID_RSP_CREDITS 2

// query index that reads the random source
`define CPUID_RANDOM_INDEX 31

`endif

// ==== rtl/cpuIdPkg.sv ====
`default_nettype none

package cpuIdPkg;

	// what a query index asks for
	typedef enum logic [1:0] {
		classIdent   = 2'd0,
		classFeature = 2'd1,
		classZero    = 2'd2,
		classRandom  = 2'd3
	} queryClass_e;

	// field view of the feature word
	typedef struct packed {
		logic [33:0] reserved;
		logic [21:0] flags;
		logic [3:0]  pad;
		logic [3:0]  coreTag;
	} featureFields_s;

	// feature word, built by fields and sent as a raw word
	typedef union packed {
		logic [63:0]    raw;
		featureFields_s fields;
	} featureWord_u;

	// one item moving between the pipeline stages
	typedef struct packed {
		queryClass_e queryClass;
		logic [63:0] resLo;
		logic [63:0] resHi;
	} stagePayload_s;

endpackage

`default_nettype wire

// ==== rtl/cpuIdStageIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cpuIdStageIf;
	import cpuIdPkg::*;

	// single-cycle strobe from the upstream stage
	logic          valid;
	logic [4:0]    index;
	queryClass_e   queryClass;
	stagePayload_s payload;

	modport source (
		output valid,
		output index,
		output queryClass,
		output payload
	);

	modport sink (
		input valid,
		input index,
		input queryClass,
		input payload
	);

endinterface

`default_nettype wire

// ==== rtl/noiseRng.sv ====
`timescale 1ns/1ps
`default_nettype none

module noiseRng (
	input logic         clock,
	input logic         rstN,
	input logic         noise,
	output logic [63:0] randomWord
);

	logic [31:0] rngA;
	logic [31:0] rngB;
	logic [31:0] nextA;
	logic [31:0] nextB;
	logic        bitA;
	logic        bitB;
	logic        bitC;
	logic        bitD;
	logic        bitAL;
	logic        bitBL;
	logic        bitCL;
	logic        bitDL;
	logic [3:0]  noiseSync;
	logic        noiseBit;

	// each feedback bit mixes in the other register's previous bit
	always_comb begin
		bitA = rngA[1] ^ rngA[3] ^ rngA[5] ^ rngA[7] ^ noiseBit ^ bitBL ^ 1'b1;
		bitB = rngB[1] ^ rngB[3] ^ rngB[5] ^ rngB[7] ^ noiseBit ^ bitAL ^ 1'b1;
		bitC = rngA[17] ^ rngA[19] ^ rngA[21] ^ rngA[23] ^ noiseBit ^ bitDL ^ 1'b1;
		bitD = rngB[17] ^ rngB[19] ^ rngB[21] ^ rngB[23] ^ noiseBit ^ bitCL ^ 1'b1;
		// A shifts left, B shifts right, each with a mid-word tap
		nextA = {rngA[30:16], rngA[15] ^ bitC, rngA[14:0], bitA};
		nextB = {bitB, rngB[31:17], rngB[16] ^ bitD, rngB[15:1]};
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			rngA <= 32'h1B873593;
			rngB <= 32'hCC9E2D51;
			{bitAL, bitBL, bitCL, bitDL} <= 4'b0000;
			noiseSync <= 4'b0000;
			noiseBit <= 1'b0;
		end else begin
			rngA <= nextA;
			rngB <= nextB;
			{bitAL, bitBL, bitCL, bitDL} <= {bitA, bitB, bitC, bitD};
			noiseSync <= {noiseSync[2:0], noise};
			// edge detect on the synchronized noise
			noiseBit <= noiseSync[3] ^ noiseSync[2];
		end
	end

	// interleave nibbles, A from the top down and B from the bottom up
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			randomWord[63 - 8 * i -: 4] = rngA[31 - 4 * i -: 4];
			randomWord[59 - 8 * i -: 4] = rngB[4 * i +: 4];
		end
	end

	rngAlive: assert property (@(posedge clock) disable iff (!rstN)
		(rngA != '0) && (rngB != '0))
		else $error("random source register collapsed to zero");

endmodule

`default_nettype wire

// ==== rtl/cpuIdDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpuId_macros.svh"

module cpuIdDecode (
	input logic        clock,
	input logic        rstN,
	input logic        reqValid,
	input logic [4:0]  reqIndex,
	cpuIdStageIf.source toExecute
);
	import cpuIdPkg::*;

	queryClass_e indexClass;
	queryClass_e heldClass;
	logic [4:0]  heldIndex;
	logic        heldValid;

	// classify the incoming index
	always_comb begin
		case (reqIndex)
			5'd0: indexClass = classIdent;
			5'd1: indexClass = classFeature;
			5'(`CPUID_RANDOM_INDEX): indexClass = classRandom;
			default: indexClass = classZero;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			heldValid <= 1'b0;
		end else begin
			heldValid <= reqValid;
		end
	end

	// query fields, only loaded on an accepted request
	always_ff @(posedge clock) begin
		if (reqValid) begin
			heldIndex <= reqIndex;
			heldClass <= indexClass;
		end
	end

	assign toExecute.valid = heldValid;
	assign toExecute.index = heldIndex;
	assign toExecute.queryClass = heldClass;
	// empty result slot, filled in by execute
	assign toExecute.payload = '{queryClass: heldClass, resLo: '0, resHi: '0};

	// every query leaving decode carries a known class
	classKnown: assert property (@(posedge clock) disable iff (!rstN)
		toExecute.valid |-> !$isunknown(toExecute.queryClass))
		else $error("decode emitted a query with unknown class");

endmodule

`default_nettype wire

// ==== rtl/cpuIdExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpuId_macros.svh"

module cpuIdExecute (
	input logic        clock,
	input logic        rstN,
	cpuIdStageIf.sink   fromDecode,
	input logic [3:0]  coreTag,
	input logic        noise,
	cpuIdStageIf.source toResult
);
	import cpuIdPkg::*;

	logic [63:0]   randomWord;
	featureWord_u  featureWord;
	stagePayload_s result;
	stagePayload_s heldResult;
	logic [4:0]    heldIndex;
	queryClass_e   heldClass;
	logic          heldValid;

	// free-running, keeps stepping while results wait downstream
	noiseRng rng_i (
		.clock      (clock),
		.rstN       (rstN),
		.noise      (noise),
		.randomWord (randomWord)
	);

	always_comb begin
		featureWord.raw = '0;
		featureWord.fields.flags = `CPUID_FEATURE_FLAGS;
		featureWord.fields.coreTag = coreTag;
	end

	// fill the slot handed over by decode
	always_comb begin
		result = fromDecode.payload;
		case (fromDecode.queryClass)
			classIdent: result.resLo = `CPUID_IDENT;
			classFeature: result.resLo = featureWord.raw;
			classRandom: result.resLo = randomWord;
			default: result.resLo = '0;
		endcase
		// no high word content for any index
		result.resHi = '0;
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			heldValid <= 1'b0;
		end else begin
			heldValid <= fromDecode.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (fromDecode.valid) begin
			heldResult <= result;
			heldIndex <= fromDecode.index;
			heldClass <= fromDecode.queryClass;
		end
	end

	assign toResult.valid = heldValid;
	assign toResult.index = heldIndex;
	assign toResult.queryClass = heldClass;
	assign toResult.payload = heldResult;

endmodule

`default_nettype wire

// ==== rtl/cpuIdResult.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpuId_macros.svh"

module cpuIdResult (
	input logic         clock,
	input logic         rstN,
	cpuIdStageIf.sink    fromExecute,
	input logic         rspCredit,
	output logic        rspValid,
	output logic [63:0] rspLo,
	output logic [63:0] rspHi,
	output logic        reqCredit
);

	localparam int Depth = `CPUID_REQ_CREDITS;
	localparam int PtrWidth = $clog2(Depth);
	localparam int CountWidth = $clog2(Depth + 1);
	localparam int CreditWidth = $clog2(`CPUID_RSP_CREDITS + 1);

	logic [127:0]           entries [Depth];
	logic [PtrWidth-1:0]    writePtr;
	logic [PtrWidth-1:0]    readPtr;
	logic [CountWidth-1:0]  fill;
	logic [CreditWidth-1:0] rspCredits;
	logic                   push;
	logic                   pop;

	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		if (ptr == PtrWidth'(Depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign push = fromExecute.valid;
	// send only with something queued and a credit in hand
	assign pop = (fill != '0) && (rspCredits != '0);

	always_ff @(posedge clock) begin
		if (push) begin
			entries[writePtr] <= {fromExecute.payload.resHi, fromExecute.payload.resLo};
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			writePtr <= '0;
			readPtr <= '0;
			fill <= '0;
		end else begin
			if (push) begin
				writePtr <= nextPtr(writePtr);
			end
			if (pop) begin
				readPtr <= nextPtr(readPtr);
			end
			case ({push, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// response credits, returned by the consumer one at a time
	always_ff @(posedge clock) begin
		if (!rstN) begin
			rspCredits <= CreditWidth'(`CPUID_RSP_CREDITS);
		end else begin
			case ({rspCredit, pop})
				2'b10: rspCredits <= rspCredits + 1'b1;
				2'b01: rspCredits <= rspCredits - 1'b1;
				default: rspCredits <= rspCredits;
			endcase
		end
	end

	// a pop also hands a request credit back
	always_ff @(posedge clock) begin
		if (!rstN) begin
			rspValid <= 1'b0;
			reqCredit <= 1'b0;
		end else begin
			rspValid <= pop;
			reqCredit <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			{rspHi, rspLo} <= entries[readPtr];
		end
	end

	// request credits upstream must keep the queue from overflowing
	noPushWhenFull: assert property (@(posedge clock) disable iff (!rstN)
		push |-> (fill != CountWidth'(Depth)))
		else $error("result pushed into a full queue");

	noRspWithoutCredit: assert property (@(posedge clock) disable iff (!rstN)
		rspValid |-> ($past(rspCredits) != '0))
		else $error("response sent without a credit");

	creditBound: assert property (@(posedge clock) disable iff (!rstN)
		rspCredits <= CreditWidth'(`CPUID_RSP_CREDITS))
		else $error("consumer returned more credits than granted");

endmodule

`default_nettype wire

// ==== rtl/cpuIdUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuIdUnit (
	input logic         clock,
	input logic         rstN,
	input logic         reqValid,
	input logic [4:0]   reqIndex,
	input logic [3:0]   coreTag,
	input logic         noise,
	input logic         rspCredit,
	output logic        reqCredit,
	output logic        rspValid,
	output logic [63:0] rspLo,
	output logic [63:0] rspHi
);

	// stage hops
	cpuIdStageIf decodeHop ();
	cpuIdStageIf executeHop ();

	cpuIdDecode decode_i (
		.clock     (clock),
		.rstN      (rstN),
		.reqValid  (reqValid),
		.reqIndex  (reqIndex),
		.toExecute (decodeHop.source)
	);

	// result words formed here, one cycle after decode
	cpuIdExecute execute_i (
		.clock      (clock),
		.rstN       (rstN),
		.fromDecode (decodeHop.sink),
		.coreTag    (coreTag),
		.noise      (noise),
		.toResult   (executeHop.source)
	);

	// queue and both credit loops
	cpuIdResult result_i (
		.clock       (clock),
		.rstN        (rstN),
		.fromExecute (executeHop.sink),
		.rspCredit   (rspCredit),
		.rspValid    (rspValid),
		.rspLo       (rspLo),
		.rspHi       (rspHi),
		.reqCredit   (reqCredit)
	);

endmodule

`default_nettype wire

// ==== test/cpuIdUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpuId_macros.svh"

module cpuIdUnitTb;

	// withheld consumer, requester keeps sending until queue and credits are used up
	localparam int WithholdQueries = `CPUID_REQ_CREDITS + `CPUID_RSP_CREDITS;
	// queries over all tests, sets the cycle limit
	localparam int TotalQueries = 6 + 6 + 20 + 8 + 40 + WithholdQueries;
	localparam int TimeoutCycles = 20 * TotalQueries;

	logic        clock = 1'b0;
	logic        rstN;
	logic        reqValid;
	logic [4:0]  reqIndex;
	logic [3:0]  coreTag;
	logic        noise;
	logic        rspCredit;
	logic        reqCredit;
	logic        rspValid;
	logic [63:0] rspLo;
	logic [63:0] rspHi;

	integer      seed = 32'h4500a72b;
	int          cycles = 0;
	int          errorCount = 0;
	int          checkCount = 0;
	int          testCount = 0;
	int          testStartErrors = 0;
	int          reqCreditsHeld = `CPUID_REQ_CREDITS;
	int          unitCredits = `CPUID_RSP_CREDITS;
	int          pendingReturn = 0;
	int          rspCount = 0;
	int          reqCreditCount = 0;
	logic        withhold = 1'b0;
	logic [63:0] lastRandom = '0;
	logic        haveRandom = 1'b0;
	logic [63:0] expLo [$];
	logic        expRandom [$];

	cpuIdUnit cpuIdUnit_i (
		.clock     (clock),
		.rstN      (rstN),
		.reqValid  (reqValid),
		.reqIndex  (reqIndex),
		.coreTag   (coreTag),
		.noise     (noise),
		.rspCredit (rspCredit),
		.reqCredit (reqCredit),
		.rspValid  (rspValid),
		.rspLo     (rspLo),
		.rspHi     (rspHi)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TimeoutCycles) begin
			$display("timeout after %0d cycles with %0d responses still owed", cycles, expLo.size());
			$display(">>> FAIL");
			$finish;
		end
	end

	// expected low word for a fixed-value index
	function automatic logic [63:0] expectedLo(input logic [4:0] idx, input logic [3:0] tag);
		if (idx == 5'd0) begin
			return `CPUID_IDENT;
		end
		if (idx == 5'd1) begin
			return {34'd0, 22'(`CPUID_FEATURE_FLAGS), 4'd0, tag};
		end
		return '0;
	endfunction

	task automatic fail(input string what, input logic [63:0] got, input logic [63:0] exp);
		$display("CHECK FAILED t=%0t %s got %h expected %h", $time, what, got, exp);
		errorCount++;
	endtask

	// consumer side, credits come back after random delays
	always @(posedge clock) begin
		#1;
		noise = 1'($random(seed));
		rspCredit = 1'b0;
		if (rstN && !withhold && pendingReturn > 0 && ($random(seed) & 1)) begin
			rspCredit = 1'b1;
			pendingReturn--;
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clock) begin
		if (rstN) begin
			if (reqCredit) begin
				reqCreditsHeld++;
				reqCreditCount++;
			end
			if (rspValid) begin
				rspCount++;
				if (unitCredits == 0) begin
					$display("t=%0t response sent while no response credit was granted", $time);
					errorCount++;
				end
				unitCredits--;
				pendingReturn++;
				checkCount++;
				if (rspHi != '0) fail("rspHi", rspHi, '0);
				if (expLo.size() == 0) begin
					$display("t=%0t response arrived with no query outstanding", $time);
					errorCount++;
				end else if (expRandom.pop_front()) begin
					void'(expLo.pop_front());
					if (rspLo == '0) begin
						$display("t=%0t random read returned zero", $time);
						errorCount++;
					end
					if (haveRandom && rspLo == lastRandom) fail("rspLo (repeat)", rspLo, lastRandom);
					lastRandom = rspLo;
					haveRandom = 1'b1;
				end else begin
					if (rspLo != expLo[0]) fail("rspLo", rspLo, expLo[0]);
					void'(expLo.pop_front());
				end
			end
			if (rspCredit) unitCredits++;
			if (reqCreditsHeld > `CPUID_REQ_CREDITS) begin
				$display("t=%0t unit returned more request credits than it was given", $time);
				errorCount++;
			end
			if (reqCreditCount != rspCount) fail("reqCredit count", reqCreditCount, rspCount);
		end
	end

	task automatic idleCycle();
		@(posedge clock);
		#1;
		reqValid = 1'b0;
	endtask

	task automatic sendQuery(input logic [4:0] idx);
		int gap;
		gap = $unsigned($random(seed)) % 3;
		repeat (gap) idleCycle();
		@(posedge clock);
		#1;
		while (reqCreditsHeld == 0) begin
			reqValid = 1'b0;
			@(posedge clock);
			#1;
		end
		reqValid = 1'b1;
		reqIndex = idx;
		reqCreditsHeld--;
		expLo.push_back(expectedLo(idx, coreTag));
		expRandom.push_back(idx == 5'(`CPUID_RANDOM_INDEX));
	endtask

	task automatic drain();
		idleCycle();
		while (expLo.size() != 0 || pendingReturn != 0) idleCycle();
		repeat (2) idleCycle();
	endtask

	task automatic finishTest(input string name, input int queries);
		testCount++;
		$display("test %-9s %3d queries, %0d errors", name, queries, errorCount - testStartErrors);
		testStartErrors = errorCount;
	endtask

	initial begin
		int held;
		rstN = 1'b0;
		reqValid = 1'b0;
		reqIndex = '0;
		coreTag = '0;
		noise = 1'b0;
		rspCredit = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		rstN = 1'b1;

		repeat (6) sendQuery(5'd0);
		drain();
		finishTest("identity", 6);

		coreTag = 4'($random(seed));
		repeat (6) sendQuery(5'd1);
		drain();
		finishTest("feature", 6);

		repeat (20) sendQuery(5'(2 + $unsigned($random(seed)) % 29));
		drain();
		finishTest("zero", 20);

		repeat (8) sendQuery(5'(`CPUID_RANDOM_INDEX));
		drain();
		finishTest("random", 8);

		coreTag = 4'($random(seed));
		repeat (40) sendQuery(5'($random(seed)));
		drain();
		finishTest("mixed", 40);

		// consumer holds its credits back, only two responses fit
		// and the returned request credits refill the queue to its depth
		withhold = 1'b1;
		held = rspCount;
		repeat (WithholdQueries) sendQuery(5'($random(seed)));
		repeat (30) idleCycle();
		checkCount++;
		if (rspCount - held > `CPUID_RSP_CREDITS) begin
			fail("responses while withheld", rspCount - held, `CPUID_RSP_CREDITS);
		end
		if (expLo.size() > `CPUID_REQ_CREDITS) begin
			$display("%0d queries outstanding, more than the %0d request credits",
				expLo.size(), `CPUID_REQ_CREDITS);
			errorCount++;
		end
		withhold = 1'b0;
		drain();
		finishTest("withhold", WithholdQueries);

		$display("%0d tests, %0d responses, %0d checks, %0d errors",
			testCount, rspCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/cpuIdPkg.sv
rtl/cpuIdStageIf.sv
rtl/noiseRng.sv
rtl/cpuIdDecode.sv
rtl/cpuIdExecute.sv
rtl/cpuIdResult.sv
rtl/cpuIdUnit.sv
test/cpuIdUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpuIdUnit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module cpuIdUnitTb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -qx '>>> PASS' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
